// ==== src/plic_consts.svh ====
// interrupt controller sizing and register map, include wherever the PLIC constants are needed
`ifndef PLIC_CONSTS_SVH
`define PLIC_CONSTS_SVH

//////////////////////////////////////////////////
// sizing
//////////////////////////////////////////////////

// source ids run 1..N, id 0 means no interrupt
`define PLIC_NUM_SOURCES 8
`define PLIC_NUM_HARTS 1
// one M and one S context per hart
`define PLIC_NUM_TARGETS (2 * `PLIC_NUM_HARTS)
`define PLIC_PRIO_WIDTH 3

//////////////////////////////////////////////////
// register map
//////////////////////////////////////////////////

`define PLIC_BASE 32'h0c00_0000
// priority of source n sits at 4*n
`define PLIC_PENDING_OFS 32'h0000_1000
`define PLIC_ENABLE_OFS 32'h0000_2000
`define PLIC_ENABLE_STRIDE 32'h0000_0080
// threshold at the context base, claim/complete 4 bytes above
`define PLIC_CTX_OFS 32'h0020_0000
`define PLIC_CTX_STRIDE 32'h0000_1000

`endif

// ==== src/plic_pkg.sv ====
// shared interrupt types, imported by the PLIC modules that pass priorities and source ids
`default_nettype none

`include "plic_consts.svh"

package plic_pkg;

  // one priority level, 0 never interrupts
  typedef logic [`PLIC_PRIO_WIDTH-1:0] prio_t;

  // wide enough for 0..NUM_SOURCES
  typedef logic [$clog2(`PLIC_NUM_SOURCES + 1)-1:0] src_id_t;

  // indexed by source id, bit 0 does not exist
  typedef logic [`PLIC_NUM_SOURCES:1] src_vec_t;

  // priority per source, indexed by source id
  typedef prio_t [`PLIC_NUM_SOURCES:1] prio_arr_t;

endpackage

`default_nettype wire

// ==== src/reg_bus_if.sv ====
// 32-bit register bus between the AXI-lite adapter and the PLIC register file
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

  // access happens in every cycle with valid high
  logic        valid;
  logic        write;
  // byte offset from the PLIC base
  logic [31:0] addr;
  logic [31:0] wdata;
  // combinational answer from the register file
  logic [31:0] rdata;

  modport adapter (
    output valid, write, addr, wdata,
    input  rdata
  );

  modport regs (
    input  valid, write, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== src/plic_axi_adapter.sv ====
// AXI-lite slave in front of the PLIC, turns 64-bit accesses into two 32-bit register accesses
`timescale 1ns/1ps
`default_nettype none

`include "plic_consts.svh"

module plic_axi_adapter (
  input  logic        clk_i,
  input  logic        rst_ni,
  // write address
  input  logic        aw_valid_i,
  output logic        aw_ready_o,
  input  logic [31:0] aw_addr_i,
  input  logic [2:0]  aw_size_i,
  // write data
  input  logic        w_valid_i,
  output logic        w_ready_o,
  input  logic [63:0] w_data_i,
  input  logic [7:0]  w_strb_i,
  // write response
  output logic        b_valid_o,
  input  logic        b_ready_i,
  // read address
  input  logic        ar_valid_i,
  output logic        ar_ready_o,
  input  logic [31:0] ar_addr_i,
  input  logic [2:0]  ar_size_i,
  // read data
  output logic        r_valid_o,
  input  logic        r_ready_i,
  output logic [63:0] r_data_o,
  reg_bus_if.adapter  bus
);

  localparam logic [2:0] SizeDword = 3'b011;

  typedef enum logic [2:0] {Idle, WriteSecond, ReadSecond, WriteResp, ReadResp} state_e;

  state_e      state_d, state_q;
  logic        idle;
  logic        wr_acc, rd_acc;
  logic [31:0] waddr, raddr;
  logic [31:0] addr_q;
  logic [31:0] wdata_hi_q;
  logic        strb_hi_q;
  logic [31:0] rword_q;

  // offsets relative to the PLIC base
  assign waddr = aw_addr_i - `PLIC_BASE;
  assign raddr = ar_addr_i - `PLIC_BASE;

  // aw and w always come together, write wins
  assign idle   = (state_q == Idle);
  assign wr_acc = idle && aw_valid_i && w_valid_i;
  assign rd_acc = idle && ar_valid_i && !wr_acc;

  assign aw_ready_o = idle;
  assign w_ready_o  = idle;
  assign ar_ready_o = idle;

  assign b_valid_o = (state_q == WriteSecond) || (state_q == WriteResp);
  assign r_valid_o = (state_q == ReadSecond) || (state_q == ReadResp);
  // high word comes straight from the register file on the handshake
  assign r_data_o  = {bus.rdata, rword_q};

  //////////////////////////////////////////////////
  // access sequencing
  //////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d   = state_q;
    bus.valid = 1'b0;
    bus.write = 1'b0;
    // second access of a 64-bit transfer by default
    bus.addr  = addr_q + 32'h4;
    bus.wdata = wdata_hi_q;
    unique case (state_q)
      Idle: begin
        if (wr_acc) begin
          bus.valid = |w_strb_i[3:0];
          bus.write = 1'b1;
          bus.addr  = waddr;
          bus.wdata = w_data_i[31:0];
          state_d   = (aw_size_i == SizeDword) ? WriteSecond : WriteResp;
        end else if (rd_acc) begin
          bus.valid = 1'b1;
          bus.addr  = raddr;
          state_d   = (ar_size_i == SizeDword) ? ReadSecond : ReadResp;
        end
      end
      // high word only once the response is taken
      WriteSecond: begin
        if (b_ready_i) begin
          bus.valid = strb_hi_q;
          bus.write = 1'b1;
          state_d   = Idle;
        end
      end
      ReadSecond: begin
        if (r_ready_i) begin
          bus.valid = 1'b1;
          state_d   = Idle;
        end
      end
      WriteResp: begin
        if (b_ready_i) begin
          state_d = Idle;
        end
      end
      ReadResp: begin
        if (r_ready_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // transfer payload
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_acc) begin
      addr_q     <= waddr;
      wdata_hi_q <= w_data_i[63:32];
      strb_hi_q  <= |w_strb_i[7:4];
    end else if (rd_acc) begin
      addr_q  <= raddr;
      rword_q <= bus.rdata;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_one_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(r_valid_o && b_valid_o));

  // a stalled 32-bit response must not touch the registers
  a_no_access_in_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == WriteResp || state_q == ReadResp) |-> !bus.valid);

endmodule

`default_nettype wire

// ==== src/plic_gateway.sv ====
// per-source interrupt gateway, turns level or edge inputs into pending bits for the targets
`timescale 1ns/1ps
`default_nettype none

`include "plic_consts.svh"

module plic_gateway import plic_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  src_vec_t irq_sources_i,
  // 1 selects edge capture
  input  src_vec_t irq_le_i,
  input  logic     claim_valid_i,
  input  src_id_t  claim_id_i,
  input  logic     complete_valid_i,
  input  src_id_t  complete_id_i,
  output src_vec_t pending_o
);

  src_vec_t src_q;
  src_vec_t pending_q, in_service_q;
  src_vec_t claim_vec, complete_vec;
  src_vec_t set_vec;

  // decode claim and complete ids into one-hot vectors
  always_comb begin : p_decode
    for (int k = 1; k <= `PLIC_NUM_SOURCES; k++) begin
      claim_vec[k]    = claim_valid_i && (claim_id_i == src_id_t'(k));
      complete_vec[k] = complete_valid_i && (complete_id_i == src_id_t'(k));
    end
  end

  // level while high, edge on rising input, neither while in service
  assign set_vec = ~in_service_q &
                   ((irq_sources_i & ~irq_le_i) | (irq_sources_i & ~src_q & irq_le_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_gateway
    if (!rst_ni) begin
      src_q        <= '0;
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      src_q        <= irq_sources_i;
      // claim beats a new request in the same cycle
      pending_q    <= (pending_q | set_vec) & ~claim_vec;
      in_service_q <= (in_service_q | claim_vec) & ~complete_vec;
    end
  end

  assign pending_o = pending_q;

  a_pend_xor_service: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pending_q & in_service_q) == '0);

endmodule

`default_nettype wire

// ==== src/plic_regs.sv ====
// PLIC register file, decodes register-bus offsets and raises claim and complete pulses
`timescale 1ns/1ps
`default_nettype none

`include "plic_consts.svh"

module plic_regs import plic_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  reg_bus_if.regs                          bus,
  input  src_vec_t                         pending_i,
  input  src_id_t  [`PLIC_NUM_TARGETS-1:0] best_id_i,
  output prio_arr_t                        prio_o,
  output src_vec_t [`PLIC_NUM_TARGETS-1:0] enable_o,
  output prio_t    [`PLIC_NUM_TARGETS-1:0] threshold_o,
  output logic                             claim_valid_o,
  output src_id_t                          claim_id_o,
  output logic                             complete_valid_o,
  output src_id_t                          complete_id_o
);

  localparam int unsigned NumSrc = `PLIC_NUM_SOURCES;
  localparam int unsigned NumTgt = `PLIC_NUM_TARGETS;
  localparam int unsigned PrioW  = `PLIC_PRIO_WIDTH;

  prio_arr_t                prio_q;
  src_vec_t  [NumTgt-1:0]   enable_q;
  prio_t     [NumTgt-1:0]   threshold_q;
  logic                     wr, rd;

  function automatic logic [31:0] enable_ofs(int unsigned t);
    return `PLIC_ENABLE_OFS + `PLIC_ENABLE_STRIDE * t;
  endfunction

  // threshold of context t, claim/complete sits 4 above
  function automatic logic [31:0] ctx_ofs(int unsigned t);
    return `PLIC_CTX_OFS + `PLIC_CTX_STRIDE * t;
  endfunction

  assign wr = bus.valid && bus.write;
  assign rd = bus.valid && !bus.write;

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cfg
    if (!rst_ni) begin
      prio_q      <= '0;
      enable_q    <= '0;
      threshold_q <= '0;
    end else if (wr) begin
      for (int unsigned n = 1; n <= NumSrc; n++) begin
        if (bus.addr == 32'(4 * n)) begin
          prio_q[n] <= bus.wdata[PrioW-1:0];
        end
      end
      for (int unsigned t = 0; t < NumTgt; t++) begin
        if (bus.addr == enable_ofs(t)) begin
          enable_q[t] <= bus.wdata[NumSrc:1];
        end
        if (bus.addr == ctx_ofs(t)) begin
          threshold_q[t] <= bus.wdata[PrioW-1:0];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read mux and claim/complete
  //////////////////////////////////////////////////

  always_comb begin : p_read
    bus.rdata        = '0;
    claim_valid_o    = 1'b0;
    claim_id_o       = '0;
    complete_valid_o = 1'b0;
    complete_id_o    = bus.wdata[$bits(src_id_t)-1:0];
    for (int unsigned n = 1; n <= NumSrc; n++) begin
      if (bus.addr == 32'(4 * n)) begin
        bus.rdata = 32'(prio_q[n]);
      end
    end
    // bit k of the pending word is source k
    if (bus.addr == `PLIC_PENDING_OFS) begin
      bus.rdata = 32'({pending_i, 1'b0});
    end
    for (int unsigned t = 0; t < NumTgt; t++) begin
      if (bus.addr == enable_ofs(t)) begin
        bus.rdata = 32'({enable_q[t], 1'b0});
      end
      if (bus.addr == ctx_ofs(t)) begin
        bus.rdata = 32'(threshold_q[t]);
      end
      if (bus.addr == ctx_ofs(t) + 32'h4) begin
        bus.rdata = 32'(best_id_i[t]);
        // a read claims, a write completes
        if (rd && best_id_i[t] != '0) begin
          claim_valid_o = 1'b1;
          claim_id_o    = best_id_i[t];
        end
        if (wr) begin
          complete_valid_o = 1'b1;
        end
      end
    end
  end

  assign prio_o      = prio_q;
  assign enable_o    = enable_q;
  assign threshold_o = threshold_q;

  a_claim_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    claim_valid_o |-> (claim_id_o <= src_id_t'(NumSrc)));

endmodule

`default_nettype wire

// ==== src/plic_target.sv ====
// priority selector for one interrupt context, drives its irq line and the id a claim returns
`timescale 1ns/1ps
`default_nettype none

`include "plic_consts.svh"

module plic_target import plic_pkg::*; (
  input  src_vec_t  pending_i,
  input  src_vec_t  enable_i,
  input  prio_arr_t prio_i,
  input  prio_t     threshold_i,
  output logic      irq_o,
  // 0 when nothing qualifies
  output src_id_t   best_id_o
);

  prio_t   best_prio;
  src_id_t best_id;

  // strictly greater keeps the lowest id on a tie,
  // and starting at 0 drops priority-0 sources
  always_comb begin : p_select
    best_prio = '0;
    best_id   = '0;
    for (int k = 1; k <= `PLIC_NUM_SOURCES; k++) begin
      if (pending_i[k] && enable_i[k] && (prio_i[k] > best_prio)) begin
        best_prio = prio_i[k];
        best_id   = src_id_t'(k);
      end
    end
  end

  assign irq_o     = (best_prio > threshold_i);
  assign best_id_o = best_id;

endmodule

`default_nettype wire

// ==== src/riscv_plic_subsys.sv ====
// PLIC subsystem top, AXI-lite slave ports in and one interrupt line per hart context out
`timescale 1ns/1ps
`default_nettype none

`include "plic_consts.svh"

module riscv_plic_subsys import plic_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         aw_valid_i,
  output logic                         aw_ready_o,
  input  logic [31:0]                  aw_addr_i,
  input  logic [2:0]                   aw_size_i,
  input  logic                         w_valid_i,
  output logic                         w_ready_o,
  input  logic [63:0]                  w_data_i,
  input  logic [7:0]                   w_strb_i,
  output logic                         b_valid_o,
  input  logic                         b_ready_i,
  input  logic                         ar_valid_i,
  output logic                         ar_ready_o,
  input  logic [31:0]                  ar_addr_i,
  input  logic [2:0]                   ar_size_i,
  output logic                         r_valid_o,
  input  logic                         r_ready_i,
  output logic [63:0]                  r_data_o,
  input  src_vec_t                     irq_sources_i,
  // 1 means edge
  input  src_vec_t                     irq_le_i,
  // 2h is M context of hart h, 2h+1 its S context
  output logic [`PLIC_NUM_TARGETS-1:0] irq_o
);

  localparam int unsigned NumTgt = `PLIC_NUM_TARGETS;

  src_vec_t              pending;
  prio_arr_t             prio;
  src_vec_t [NumTgt-1:0] enable;
  prio_t    [NumTgt-1:0] threshold;
  src_id_t  [NumTgt-1:0] best_id;
  logic                  claim_valid, complete_valid;
  src_id_t               claim_id, complete_id;

  reg_bus_if reg_bus ();

  //////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////

  plic_axi_adapter u_axi_adapter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_size_i  (aw_size_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_size_i  (ar_size_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .bus        (reg_bus.adapter)
  );

  plic_regs u_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus              (reg_bus.regs),
    .pending_i        (pending),
    .best_id_i        (best_id),
    .prio_o           (prio),
    .enable_o         (enable),
    .threshold_o      (threshold),
    .claim_valid_o    (claim_valid),
    .claim_id_o       (claim_id),
    .complete_valid_o (complete_valid),
    .complete_id_o    (complete_id)
  );

  //////////////////////////////////////////////////
  // interrupt side
  //////////////////////////////////////////////////

  plic_gateway u_gateway (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .irq_sources_i    (irq_sources_i),
    .irq_le_i         (irq_le_i),
    .claim_valid_i    (claim_valid),
    .claim_id_i       (claim_id),
    .complete_valid_i (complete_valid),
    .complete_id_i    (complete_id),
    .pending_o        (pending)
  );

  for (genvar t = 0; t < NumTgt; t++) begin : g_target
    plic_target u_target (
      .pending_i   (pending),
      .enable_i    (enable[t]),
      .prio_i      (prio),
      .threshold_i (threshold[t]),
      .irq_o       (irq_o[t]),
      .best_id_o   (best_id[t])
    );
  end

endmodule

`default_nettype wire

// ==== tb/tb_riscv_plic_subsys.sv ====
// directed testbench for the PLIC subsystem that runs as the simulation top with sim.f
`timescale 1ns/1ps
`default_nettype none

`include "plic_consts.svh"

module tb_riscv_plic_subsys;

  localparam int unsigned TimeoutCycles = 100;
  localparam logic [2:0]  Size32 = 3'd2;
  localparam logic [2:0]  Size64 = 3'd3;
  localparam logic [31:0] PrioMask = (32'h1 << `PLIC_PRIO_WIDTH) - 32'h1;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         aw_valid, aw_ready, w_valid, w_ready;
  logic [31:0]                  aw_addr, ar_addr;
  logic [2:0]                   aw_size, ar_size;
  logic [63:0]                  w_data, r_data;
  logic [7:0]                   w_strb;
  logic                         b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready;
  logic [`PLIC_NUM_SOURCES:1]   irq_sources, irq_le;
  logic [`PLIC_NUM_TARGETS-1:0] irq;
  logic [7:0]                   lfsr_state;

  riscv_plic_subsys u_riscv_plic_subsys (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (aw_valid),
    .aw_ready_o    (aw_ready),
    .aw_addr_i     (aw_addr),
    .aw_size_i     (aw_size),
    .w_valid_i     (w_valid),
    .w_ready_o     (w_ready),
    .w_data_i      (w_data),
    .w_strb_i      (w_strb),
    .b_valid_o     (b_valid),
    .b_ready_i     (b_ready),
    .ar_valid_i    (ar_valid),
    .ar_ready_o    (ar_ready),
    .ar_addr_i     (ar_addr),
    .ar_size_i     (ar_size),
    .r_valid_o     (r_valid),
    .r_ready_i     (r_ready),
    .r_data_o      (r_data),
    .irq_sources_i (irq_sources),
    .irq_le_i      (irq_le),
    .irq_o         (irq)
  );

  initial begin : p_clock
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // fibonacci lfsr with taps 8 6 5 4 and one step per bit
  function automatic logic [31:0] lfsr_take(input int unsigned nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      fb         = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
      lfsr_state = {lfsr_state[6:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // register map offsets
  function automatic logic [31:0] prio_ofs(input int unsigned n);
    return 32'(4 * n);
  endfunction

  function automatic logic [31:0] enable_ofs(input int unsigned t);
    return `PLIC_ENABLE_OFS + `PLIC_ENABLE_STRIDE * t;
  endfunction

  function automatic logic [31:0] threshold_ofs(input int unsigned t);
    return `PLIC_CTX_OFS + `PLIC_CTX_STRIDE * t;
  endfunction

  function automatic logic [31:0] claim_ofs(input int unsigned t);
    return threshold_ofs(t) + 32'h4;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic axi_write(input logic [31:0] ofs, input logic [2:0] size,
                           input logic [63:0] data, input logic [7:0] strb);
    int unsigned cnt;
    @(posedge clk_i);
    aw_valid <= 1'b1;
    aw_addr  <= `PLIC_BASE + ofs;
    aw_size  <= size;
    w_valid  <= 1'b1;
    w_data   <= data;
    w_strb   <= strb;
    cnt = 0;
    @(negedge clk_i);
    while (!(aw_ready && w_ready)) begin
      cnt++;
      if (cnt > TimeoutCycles) begin
        abort_run("timeout waiting for aw_ready_o and w_ready_o");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!b_valid) begin
      cnt++;
      if (cnt > TimeoutCycles) begin
        abort_run("timeout waiting for b_valid_o");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    b_ready <= 1'b1;
    @(posedge clk_i);
    b_ready <= 1'b0;
  endtask

  // stall holds r_ready low for that many cycles once the response shows up
  task automatic axi_read(input logic [31:0] ofs, input logic [2:0] size,
                          input int unsigned stall, output logic [63:0] data);
    int unsigned cnt;
    @(posedge clk_i);
    ar_valid <= 1'b1;
    ar_addr  <= `PLIC_BASE + ofs;
    ar_size  <= size;
    cnt = 0;
    @(negedge clk_i);
    while (!ar_ready) begin
      cnt++;
      if (cnt > TimeoutCycles) begin
        abort_run("timeout waiting for ar_ready_o");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ar_valid <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!r_valid) begin
      cnt++;
      if (cnt > TimeoutCycles) begin
        abort_run("timeout waiting for r_valid_o");
      end
      @(negedge clk_i);
    end
    for (int unsigned i = 0; i < stall; i++) begin
      @(negedge clk_i);
      check("r_valid_o", r_valid, 1'b1);
      check("ar_ready_o", ar_ready, 1'b0);
      check("aw_ready_o", aw_ready, 1'b0);
      check("w_ready_o", w_ready, 1'b0);
    end
    @(posedge clk_i);
    r_ready <= 1'b1;
    @(negedge clk_i);
    data = r_data;
    @(posedge clk_i);
    r_ready <= 1'b0;
  endtask

  task automatic write_reg(input logic [31:0] ofs, input logic [31:0] val);
    axi_write(ofs, Size32, {32'h0, val}, 8'h0f);
  endtask

  task automatic read_reg(input logic [31:0] ofs, output logic [31:0] val);
    logic [63:0] rd;
    axi_read(ofs, Size32, 0, rd);
    val = rd[31:0];
  endtask

  task automatic wait_irq(input int unsigned t, input logic level);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (irq[t] !== level) begin
      cnt++;
      if (cnt > TimeoutCycles) begin
        abort_run($sformatf("timeout waiting for irq_o[%0d] to become %0b", t, level));
      end
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_state();
    @(negedge clk_i);
    check("irq_o", irq, '0);
    check("r_valid_o", r_valid, 1'b0);
    check("b_valid_o", b_valid, 1'b0);
    check("aw_ready_o", aw_ready, 1'b1);
    check("w_ready_o", w_ready, 1'b1);
    check("ar_ready_o", ar_ready, 1'b1);
  endtask

  task automatic priority_readback();
    logic [31:0] p2, p3, val;
    logic [63:0] rd;
    p2 = lfsr_take(8);
    p3 = lfsr_take(8);
    // sources 2 and 3 in one 64-bit write
    axi_write(prio_ofs(2), Size64, {p3, p2}, 8'hff);
    axi_read(prio_ofs(2), Size64, 0, rd);
    check("r_data_o", rd, {p3 & PrioMask, p2 & PrioMask});
    read_reg(`PLIC_PENDING_OFS, val);
    check("r_data_o[31:0]", val, 32'h0);
  endtask

  task automatic threshold_gating();
    write_reg(prio_ofs(5), 32'd4);
    write_reg(enable_ofs(0), 32'h1 << 5);
    write_reg(threshold_ofs(0), 32'd2);
    @(posedge clk_i);
    irq_sources[5] <= 1'b1;
    wait_irq(0, 1'b1);
    check("irq_o[1]", irq[1], 1'b0);
    // equal to the priority is not enough
    write_reg(threshold_ofs(0), 32'd4);
    @(negedge clk_i);
    check("irq_o[0]", irq[0], 1'b0);
  endtask

  task automatic claim_and_complete();
    logic [31:0] val;
    write_reg(prio_ofs(6), 32'd6);
    write_reg(enable_ofs(0), 32'h60);
    write_reg(threshold_ofs(0), 32'd0);
    @(posedge clk_i);
    irq_sources[6] <= 1'b1;
    repeat (2) @(posedge clk_i);
    read_reg(`PLIC_PENDING_OFS, val);
    check("r_data_o[31:0] pending", val, 32'h60);
    read_reg(claim_ofs(0), val);
    check("r_data_o[31:0] claim", val, 32'd6);
    // level still high but in service
    read_reg(`PLIC_PENDING_OFS, val);
    check("r_data_o[31:0] pending", val, 32'h20);
    write_reg(enable_ofs(0), 32'h1 << 6);
    @(negedge clk_i);
    check("irq_o[0]", irq[0], 1'b0);
    write_reg(claim_ofs(0), 32'd6);
    wait_irq(0, 1'b1);
    // lower id wins a tie on priority
    write_reg(prio_ofs(6), 32'd4);
    write_reg(enable_ofs(0), 32'h60);
    read_reg(claim_ofs(0), val);
    check("r_data_o[31:0] claim", val, 32'd5);
    @(posedge clk_i);
    irq_sources[5] <= 1'b0;
    irq_sources[6] <= 1'b0;
    read_reg(claim_ofs(0), val);
    check("r_data_o[31:0] claim", val, 32'd6);
    write_reg(claim_ofs(0), 32'd6);
    write_reg(claim_ofs(0), 32'd5);
    read_reg(claim_ofs(0), val);
    check("r_data_o[31:0] claim", val, 32'd0);
  endtask

  task automatic edge_capture();
    logic [31:0] val;
    write_reg(prio_ofs(3), 32'd5);
    write_reg(enable_ofs(0), 32'h1 << 3);
    @(posedge clk_i);
    irq_sources[3] <= 1'b1;
    @(posedge clk_i);
    irq_sources[3] <= 1'b0;
    wait_irq(0, 1'b1);
    read_reg(`PLIC_PENDING_OFS, val);
    check("r_data_o[31:0] pending", val, 32'h08);
    read_reg(claim_ofs(0), val);
    check("r_data_o[31:0] claim", val, 32'd3);
    @(negedge clk_i);
    check("irq_o[0]", irq[0], 1'b0);
    write_reg(claim_ofs(0), 32'd3);
    repeat (3) @(posedge clk_i);
    read_reg(`PLIC_PENDING_OFS, val);
    check("r_data_o[31:0] pending", val, 32'h0);
    read_reg(claim_ofs(0), val);
    check("r_data_o[31:0] claim", val, 32'd0);
  endtask

  task automatic stalled_claim_read();
    logic [31:0] val;
    logic [63:0] rd;
    write_reg(prio_ofs(6), 32'd6);
    write_reg(enable_ofs(0), 32'h60);
    write_reg(threshold_ofs(0), 32'd1);
    @(posedge clk_i);
    irq_sources[5] <= 1'b1;
    irq_sources[6] <= 1'b1;
    wait_irq(0, 1'b1);
    // threshold in the low word and claim in the high word
    axi_read(threshold_ofs(0), Size64, 5, rd);
    check("r_data_o", rd, {32'd6, 32'd1});
    read_reg(claim_ofs(0), val);
    check("r_data_o[31:0] claim", val, 32'd5);
  endtask

  initial begin : p_main
    lfsr_state  = 8'd40;
    rst_ni      = 1'b0;
    aw_valid    = 1'b0;
    aw_addr     = '0;
    aw_size     = '0;
    w_valid     = 1'b0;
    w_data      = '0;
    w_strb      = '0;
    b_ready     = 1'b0;
    ar_valid    = 1'b0;
    ar_addr     = '0;
    ar_size     = '0;
    r_ready     = 1'b0;
    irq_sources = '0;
    // source 3 is edge triggered
    irq_le      = '0;
    irq_le[3]   = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_state();
    priority_readback();
    threshold_gating();
    claim_and_complete();
    edge_capture();
    stalled_claim_read();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/plic_pkg.sv
src/reg_bus_if.sv
src/plic_axi_adapter.sv
src/plic_gateway.sv
src/plic_regs.sv
src/plic_target.sv
src/riscv_plic_subsys.sv
tb/tb_riscv_plic_subsys.sv

// ==== Bender.yml ====
package:
  name: riscv_plic_subsys

export_include_dirs:
  - src

sources:
  - src/plic_pkg.sv
  - src/reg_bus_if.sv
  - src/plic_axi_adapter.sv
  - src/plic_gateway.sv
  - src/plic_regs.sv
  - src/plic_target.sv
  - src/riscv_plic_subsys.sv
  - target: test
    files:
      - tb/tb_riscv_plic_subsys.sv
